// ==== Makefile ====
TOP = mips_cpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
hdl/mips_pkg.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_control.sv
hdl/mips_datapath.sv
hdl/mips_cpu.sv
test/mips_cpu_assert.sv
test/mips_cpu_tb.sv

// ==== hdl/mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [3:0]  op,
    output logic [31:0] result,
    output logic        zero
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            ALU_LUI: result = {b[15:0], 16'd0};  // Immediate to upper half
            default: result = 32'd0;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== hdl/mips_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_control (
    input  logic             clk,
    input  logic             reset,
    input  logic             waitrequest,
    input  logic             alu_zero,
    input  logic             pc_zero,
    input  mips_pkg::instr_t instr,
    output logic             read,
    output logic             write,
    output logic             active,
    output logic             pc_write,
    output logic [1:0]       pc_src,
    output logic             ir_write,
    output logic             mdr_write,
    output logic             alu_out_write,
    output logic             iord,
    output logic             alu_src_a,
    output logic [1:0]       alu_src_b,
    output logic [3:0]       alu_op,
    output logic             reg_write,
    output logic             reg_dst,
    output logic             mem_to_reg,
    output logic             imm_zero_ext
);
    import mips_pkg::*;

    state_t state;
    state_t next_state;
    state_t fetch_state;
    logic   started;
    logic   is_lw;
    logic   is_sw;

    assign is_lw       = (instr.i.op == OP_LW);
    assign is_sw       = (instr.i.op == OP_SW);
    assign fetch_state = pc_zero ? HALT : IF;  // PC of zero ends the program
    assign active      = (state != HALT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IF;
            started <= 1'b0;
        end else begin
            state   <= next_state;
            started <= 1'b1;  // First fetch one cycle after reset
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IF: begin
                if (started && !waitrequest) begin
                    next_state = ID;
                end
            end
            ID:  next_state = EX;
            EX: begin
                if ((is_lw || is_sw) && waitrequest) begin
                    next_state = EX;  // Bus request held
                end else if (is_lw) begin
                    next_state = MEM;
                end else begin
                    next_state = fetch_state;
                end
            end
            MEM:     next_state = fetch_state;
            default: next_state = HALT;
        endcase
    end

    always_comb begin
        read          = 1'b0;
        write         = 1'b0;
        pc_write      = 1'b0;
        pc_src        = 2'd0;
        ir_write      = 1'b0;
        mdr_write     = 1'b0;
        alu_out_write = 1'b0;
        iord          = 1'b0;
        alu_src_a     = 1'b0;
        alu_src_b     = 2'd0;
        alu_op        = ALU_ADD;
        reg_write     = 1'b0;
        reg_dst       = 1'b0;
        mem_to_reg    = 1'b0;
        imm_zero_ext  = 1'b0;
        case (state)
            IF: begin
                alu_src_b = 2'd1;  // PC + 4
                if (started) begin
                    read     = 1'b1;
                    ir_write = !waitrequest;
                    pc_write = !waitrequest;
                end
            end
            ID: begin
                alu_src_b     = 2'd3;  // Branch target
                alu_out_write = 1'b1;
            end
            EX: begin
                alu_src_a = 1'b1;
                case (instr.i.op)
                    OP_SPECIAL: begin
                        reg_dst   = 1'b1;
                        reg_write = 1'b1;
                        case (instr.r.func)
                            FN_ADDU: alu_op = ALU_ADD;
                            FN_SUBU: alu_op = ALU_SUB;
                            FN_AND:  alu_op = ALU_AND;
                            FN_OR:   alu_op = ALU_OR;
                            FN_XOR:  alu_op = ALU_XOR;
                            FN_SLT:  alu_op = ALU_SLT;
                            FN_JR: begin
                                reg_write = 1'b0;
                                pc_src    = 2'd3;
                                pc_write  = 1'b1;
                            end
                            default: reg_write = 1'b0;
                        endcase
                    end
                    OP_ADDIU: begin
                        alu_src_b = 2'd2;
                        reg_write = 1'b1;
                    end
                    OP_ORI: begin
                        alu_src_b    = 2'd2;
                        alu_op       = ALU_OR;
                        imm_zero_ext = 1'b1;
                        reg_write    = 1'b1;
                    end
                    OP_LUI: begin
                        alu_src_b = 2'd2;
                        alu_op    = ALU_LUI;
                        reg_write = 1'b1;
                    end
                    OP_BEQ: begin
                        alu_op   = ALU_SUB;
                        pc_src   = 2'd1;
                        pc_write = alu_zero;
                    end
                    OP_BNE: begin
                        alu_op   = ALU_SUB;
                        pc_src   = 2'd1;
                        pc_write = !alu_zero;
                    end
                    OP_J: begin
                        pc_src   = 2'd2;
                        pc_write = 1'b1;
                    end
                    OP_LW: begin
                        alu_src_b = 2'd2;
                        iord      = 1'b1;
                        read      = 1'b1;
                        mdr_write = !waitrequest;
                    end
                    OP_SW: begin
                        alu_src_b = 2'd2;
                        iord      = 1'b1;
                        write     = 1'b1;
                    end
                    default: ;  // Unknown opcode runs as a no-op
                endcase
            end
            MEM: begin
                reg_write  = 1'b1;  // MDR into rt
                mem_to_reg = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mips_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu (
    input  logic        clk,
    input  logic        reset,
    input  logic        waitrequest,
    input  logic [31:0] readdata,
    output logic        active,
    output logic [31:0] address,
    output logic [31:0] writedata,
    output logic [31:0] register_v0,
    output logic        read,
    output logic        write
);
    import mips_pkg::*;

    instr_t     instr;
    logic       alu_zero;
    logic       pc_zero;
    logic       pc_write;
    logic [1:0] pc_src;
    logic       ir_write;
    logic       mdr_write;
    logic       alu_out_write;
    logic       iord;
    logic       alu_src_a;
    logic [1:0] alu_src_b;
    logic [3:0] alu_op;
    logic       reg_write;
    logic       reg_dst;
    logic       mem_to_reg;
    logic       imm_zero_ext;

    mips_control i_control (
        .clk           (clk),
        .reset         (reset),
        .waitrequest   (waitrequest),
        .alu_zero      (alu_zero),
        .pc_zero       (pc_zero),
        .instr         (instr),
        .read          (read),
        .write         (write),
        .active        (active),
        .pc_write      (pc_write),
        .pc_src        (pc_src),
        .ir_write      (ir_write),
        .mdr_write     (mdr_write),
        .alu_out_write (alu_out_write),
        .iord          (iord),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .imm_zero_ext  (imm_zero_ext)
    );

    mips_datapath i_datapath (
        .clk           (clk),
        .reset         (reset),
        .readdata      (readdata),
        .pc_write      (pc_write),
        .pc_src        (pc_src),
        .ir_write      (ir_write),
        .mdr_write     (mdr_write),
        .alu_out_write (alu_out_write),
        .iord          (iord),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .imm_zero_ext  (imm_zero_ext),
        .address       (address),
        .writedata     (writedata),
        .register_v0   (register_v0),
        .instr         (instr),
        .alu_zero      (alu_zero),
        .pc_zero       (pc_zero)
    );

endmodule

`default_nettype wire

// ==== hdl/mips_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_datapath (
    input  logic             clk,
    input  logic             reset,
    input  logic [31:0]      readdata,
    input  logic             pc_write,
    input  logic [1:0]       pc_src,
    input  logic             ir_write,
    input  logic             mdr_write,
    input  logic             alu_out_write,
    input  logic             iord,
    input  logic             alu_src_a,
    input  logic [1:0]       alu_src_b,
    input  logic [3:0]       alu_op,
    input  logic             reg_write,
    input  logic             reg_dst,
    input  logic             mem_to_reg,
    input  logic             imm_zero_ext,
    output logic [31:0]      address,
    output logic [31:0]      writedata,
    output logic [31:0]      register_v0,
    output mips_pkg::instr_t instr,
    output logic             alu_zero,
    output logic             pc_zero
);
    import mips_pkg::*;

    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] mdr;
    logic [31:0] alu_out;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] imm_ext;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] wr_data;
    logic [4:0]  wr_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else if (pc_write) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_write) begin
            instr <= readdata;
        end
        if (mdr_write) begin
            mdr <= readdata;
        end
        if (alu_out_write) begin
            alu_out <= alu_result;
        end
    end

    assign imm_ext = imm_zero_ext ? {16'd0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};
    assign alu_a   = alu_src_a ? rs_data : pc;

    always_comb begin
        case (alu_src_b)
            2'd0:    alu_b = rt_data;
            2'd1:    alu_b = 32'd4;
            2'd2:    alu_b = imm_ext;
            default: alu_b = {imm_ext[29:0], 2'b00};  // Word offset
        endcase
    end

    always_comb begin
        case (pc_src)
            2'd0:    pc_next = alu_result;
            2'd1:    pc_next = alu_out;  // Stored branch target
            2'd2:    pc_next = {pc[31:28], instr.j.target, 2'b00};
            default: pc_next = rs_data;
        endcase
    end

    // Looks at the PC the next cycle will see
    assign pc_zero = ((pc_write ? pc_next : pc) == 32'd0);

    assign address   = iord ? alu_result : pc;
    assign writedata = rt_data;
    assign wr_addr   = reg_dst ? instr.r.rd : instr.r.rt;
    assign wr_data   = mem_to_reg ? mdr : alu_result;

    mips_regfile i_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (instr.r.rs),
        .rt_addr (instr.r.rt),
        .wr_addr (wr_addr),
        .wr_en   (reg_write),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    mips_alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

endmodule

`default_nettype wire

// ==== hdl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

    typedef enum logic [2:0] {
        IF   = 3'd0,
        ID   = 3'd1,
        EX   = 3'd2,
        MEM  = 3'd3,
        HALT = 3'd4
    } state_t;

    localparam logic [3:0] ALU_ADD = 4'd0;
    localparam logic [3:0] ALU_SUB = 4'd1;
    localparam logic [3:0] ALU_AND = 4'd2;
    localparam logic [3:0] ALU_OR  = 4'd3;
    localparam logic [3:0] ALU_XOR = 4'd4;
    localparam logic [3:0] ALU_SLT = 4'd5;
    localparam logic [3:0] ALU_LUI = 4'd6;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // Function field of SPECIAL
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] func;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target;
        } j;
    } instr_t;

endpackage

`default_nettype wire

// ==== hdl/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [4:0]  wr_addr,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];
    assign v0      = regs[2];

endmodule

`default_nettype wire

// ==== test/mips_cpu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_assert (
    input logic        clk,
    input logic        reset,
    input logic        waitrequest,
    input logic        active,
    input logic        read,
    input logic        write,
    input logic [31:0] address,
    input logic [31:0] writedata
);

    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write high together");

    // Request held while stalled
    assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
        else $error("bus request changed during waitrequest");

    assert property (@(posedge clk) disable iff (reset) !active |-> !read && !write)
        else $error("bus access while halted");

endmodule

bind mips_cpu mips_cpu_assert i_assert (
    .clk         (clk),
    .reset       (reset),
    .waitrequest (waitrequest),
    .active      (active),
    .read        (read),
    .write       (write),
    .address     (address),
    .writedata   (writedata)
);

`default_nettype wire

// ==== test/mips_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_tb;
    import mips_pkg::*;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic [31:0] address;
    logic [31:0] writedata;
    logic [31:0] register_v0;
    logic        read;
    logic        write;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] last_wr_addr;
    logic [31:0] last_wr_data;
    int unsigned lcg_state = 84903;
    int          wait_left;
    bit          busy;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          prog_len;

    mips_cpu i_dut (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .active      (active),
        .address     (address),
        .writedata   (writedata),
        .register_v0 (register_v0),
        .read        (read),
        .write       (write)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'd3;
    endfunction

    // Memory model with 0 to 3 wait states per access
    always @(negedge clk) begin
        if (reset) begin
            busy        = 1'b0;
            waitrequest = 1'b1;
        end else if (read || write) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = next_rand();
            end
            if (wait_left > 0) begin
                wait_left--;
                waitrequest = 1'b1;
            end else begin
                busy        = 1'b0;
                waitrequest = 1'b0;  // Completes on the next rising edge
                if (read) begin
                    readdata = mem.exists(address) ? mem[address] : 32'd0;
                end else begin
                    mem[address] = writedata;
                    last_wr_addr = address;
                    last_wr_data = writedata;
                end
            end
        end else begin
            waitrequest = 1'b1;
        end
    end

    function automatic logic [31:0] r_word(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                            logic [5:0] func);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, func};
    endfunction

    function automatic logic [31:0] i_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                            logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(logic [31:0] dest);
        return {OP_J, dest[27:2]};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[RESET_VECTOR + 32'(prog_len) * 4] = word;
        prog_len++;
    endtask

    task automatic new_program();
        mem.delete();
        prog_len     = 0;
        last_wr_addr = 32'hxxxx_xxxx;
        last_wr_data = 32'hxxxx_xxxx;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timed out waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic wait_halt();
        for (int i = 0; i < 2000 && active; i++) begin
            @(negedge clk);
        end
        if (active) begin
            abort_run("the core to halt");
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic reset_and_fetch();
        int e;
        e = errors;
        new_program();
        emit(r_word(5'd0, 5'd0, 5'd0, FN_JR));
        apply_reset();
        check("active", {31'd0, active}, 32'd1);
        for (int i = 0; i < 50 && !read; i++) begin
            @(negedge clk);
        end
        if (!read) begin
            abort_run("the first fetch");
        end
        check("address", address, RESET_VECTOR);
        wait_halt();
        finish_test("reset_and_fetch", e);
    endtask

    task automatic arithmetic();
        int          e;
        logic [31:0] t0, t1, t2, t3, t4, t5, t6, t7;
        e = errors;
        new_program();
        emit(i_word(OP_ADDIU, 5'd0, 5'd8, 16'hFFFB));
        emit(i_word(OP_LUI, 5'd0, 5'd9, 16'h1234));
        emit(i_word(OP_ORI, 5'd9, 5'd9, 16'hF0F0));
        emit(r_word(5'd9, 5'd8, 5'd10, FN_ADDU));
        emit(r_word(5'd9, 5'd8, 5'd11, FN_SUBU));
        emit(r_word(5'd10, 5'd11, 5'd12, FN_AND));
        emit(r_word(5'd12, 5'd9, 5'd13, FN_OR));
        emit(r_word(5'd13, 5'd8, 5'd14, FN_XOR));
        emit(r_word(5'd8, 5'd9, 5'd15, FN_SLT));
        emit(r_word(5'd14, 5'd15, 5'd2, FN_ADDU));
        emit(r_word(5'd0, 5'd0, 5'd0, FN_JR));
        t0 = {{16{1'b1}}, 16'hFFFB};  // Sign-extended immediate
        t1 = {16'h1234, 16'h0000} | {16'h0000, 16'hF0F0};
        t2 = t1 + t0;
        t3 = t1 - t0;
        t4 = t2 & t3;
        t5 = t4 | t1;
        t6 = t5 ^ t0;
        t7 = ($signed(t0) < $signed(t1)) ? 32'd1 : 32'd0;
        apply_reset();
        wait_halt();
        check("register_v0", register_v0, t6 + t7);
        finish_test("arithmetic", e);
    endtask

    task automatic load_store();
        int e;
        e = errors;
        new_program();
        mem[32'h0000_1000] = 32'hCAFE_F00D;
        emit(i_word(OP_ADDIU, 5'd0, 5'd8, 16'h1000));
        emit(i_word(OP_LUI, 5'd0, 5'd9, 16'h5A5A));
        emit(i_word(OP_ORI, 5'd9, 5'd9, 16'h1234));
        emit(i_word(OP_SW, 5'd8, 5'd9, 16'h0008));
        emit(i_word(OP_LW, 5'd8, 5'd2, 16'h0000));
        emit(r_word(5'd0, 5'd0, 5'd0, FN_JR));
        apply_reset();
        wait_halt();
        check("write address", last_wr_addr, 32'h0000_1008);
        check("writedata", last_wr_data, 32'h5A5A_1234);
        check("register_v0", register_v0, 32'hCAFE_F00D);
        finish_test("load_store", e);
    endtask

    task automatic branches();
        int          e;
        logic [31:0] expected;
        e = errors;
        new_program();
        emit(i_word(OP_ADDIU, 5'd0, 5'd8, 16'd3));
        emit(i_word(OP_ADDIU, 5'd0, 5'd9, 16'd3));
        emit(i_word(OP_BEQ, 5'd8, 5'd9, 16'd1));
        emit(i_word(OP_ADDIU, 5'd2, 5'd2, 16'd1));
        emit(i_word(OP_BNE, 5'd8, 5'd9, 16'd1));
        emit(i_word(OP_ADDIU, 5'd2, 5'd2, 16'd2));
        emit(i_word(OP_BEQ, 5'd8, 5'd0, 16'd1));
        emit(i_word(OP_ADDIU, 5'd2, 5'd2, 16'd4));
        emit(i_word(OP_BNE, 5'd8, 5'd0, 16'd1));
        emit(i_word(OP_ADDIU, 5'd2, 5'd2, 16'd8));
        emit(j_word(RESET_VECTOR + 32'd48));
        emit(i_word(OP_ADDIU, 5'd2, 5'd2, 16'd16));
        emit(i_word(OP_ADDIU, 5'd2, 5'd2, 16'd32));
        emit(r_word(5'd0, 5'd0, 5'd0, FN_JR));
        // Taken branches and J skip the marker after them
        expected = 32'd32;
        expected += (3 == 3) ? 0 : 1;
        expected += (3 != 3) ? 0 : 2;
        expected += (3 == 0) ? 0 : 4;
        expected += (3 != 0) ? 0 : 8;
        apply_reset();
        wait_halt();
        check("register_v0", register_v0, expected);
        finish_test("branches", e);
    endtask

    task automatic halt_and_noop();
        int e;
        int bus_cycles;
        e = errors;
        bus_cycles = 0;
        new_program();
        emit(i_word(OP_ADDIU, 5'd0, 5'd2, 16'h0077));
        emit(i_word(6'h3F, 5'd0, 5'd2, 16'h1111));
        emit(r_word(5'd0, 5'd0, 5'd2, 6'h3F));
        emit(r_word(5'd0, 5'd0, 5'd0, FN_JR));
        apply_reset();
        wait_halt();
        repeat (20) begin
            @(negedge clk);
            if (read || write) begin
                bus_cycles++;
            end
        end
        if (bus_cycles != 0) begin
            $display("Bus was active for %0d cycles after halt", bus_cycles);
            errors++;
        end
        check("active", {31'd0, active}, 32'd0);
        check("register_v0", register_v0, 32'h0000_0077);
        finish_test("halt_and_noop", e);
    endtask

    initial begin
        reset        = 1'b1;
        waitrequest  = 1'b1;
        readdata     = 32'd0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_and_fetch();
        arithmetic();
        load_store();
        branches();
        halt_and_noop();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
